//--- list.f
+incdir+src
src/arcade_pkg.sv
src/download_router.sv
src/program_rom.sv
src/input_mapper.sv
src/arcade_io_top.sv
bench/arcade_io_properties.sv
bench/tb_arcade_io.sv

//--- run.sh
#!/bin/sh
# Verilator build and run of the arcade IO regression

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_arcade_io \
	--Mdir obj_dir -o tb_arcade_io
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/tb_arcade_io +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

//--- bench/tb_arcade_io.sv
/*
 * Arcade IO testbench
 * Download, graphics memory with credit return, program readback, inputs
 */
`timescale 1ns/1ps
`include "arcade_consts.svh"

module tb_arcade_io;
	import arcade_pkg::*;

	localparam int N_GFX      = 32;                  // Graphics bytes for 8 words
	localparam int HOLD       = 40;                  // Credit stall length
	localparam int N_BYTES    = 8 + 2 + N_GFX + 6 * 4;
	localparam int MAX_CYCLES = 2 * (N_BYTES * 4 + HOLD + 300);

	localparam dl_addr_t DL_BASE [6] = '{25'h0C0000, 25'h0F0000, 25'h100000,
	                                     25'h110000, 25'h120000, 25'h130000};
	localparam prog_addr_t RD_BASE [6] = '{19'h00000, 19'h18000, 19'h20000,
	                                       19'h28000, 19'h30000, 19'h38000};
	localparam int WORD_OFS = 'h123;
	// Stick {up,down,left,right} and the tread pattern it should give
	localparam logic [3:0] DIRS [8] = '{4'b1010, 4'b1000, 4'b1001, 4'b0001,
	                                    4'b0101, 4'b0100, 4'b0110, 4'b0010};
	localparam player_port_t TANK_P [8] = '{8'hDF, 8'hCF, 8'hEF, 8'h6F,
	                                        8'hBF, 8'h3F, 8'h7F, 8'h9F};

	logic         clk_sys;
	logic         rst_n;
	dl_byte_t     dl;
	logic         dl_wait;
	gfx_wr_t      gfx_wr;
	logic         gfx_credit;
	prog_addr_t   prog_addr;
	prog_word_t   prog_data;
	kbd_event_t   kbd;
	joy_t         joy0;
	joy_t         joy1;
	player_port_t p1;
	player_port_t p2;
	player_port_t p3;
	player_port_t p4;
	logic [4:0]   sys_in;
	logic [63:0]  dip_sw;
	game_type_t   game_type;

	integer      seed;
	int          errors;
	int          prop_errors;
	int          cycles;
	int          owed;           // Words held by the memory model
	int          gap;
	int          gap_idx;
	int          hold_left;
	int          words_seen;
	int          delay_tab [64];
	logic        credit_now;
	logic        saw_wait;
	logic [63:0] dip_exp;
	prog_word_t  prog_exp [6][2];

	arcade_io_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// Run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles", cycles);
			$display("Regression failed");
			$finish;
		end
	end

	// ##########################################################
	// Graphics memory returning credits after a random gap
	always @(posedge clk_sys) begin
		if (!rst_n) begin
			owed       <= 0;
			gap        <= 0;
			gap_idx    <= 0;
			hold_left  <= HOLD;
			words_seen <= 0;
			gfx_credit <= 1'b0;
		end else begin
			credit_now = (owed > 0) && (hold_left == 0) && (gap == 0);
			gfx_credit <= credit_now;
			owed       <= owed + int'(gfx_wr.valid) - int'(credit_now);
			if (gfx_wr.valid)
				words_seen <= words_seen + 1;
			if (owed > 0 && hold_left > 0)
				hold_left <= hold_left - 1;  // Stall on first words
			if (credit_now) begin
				gap     <= delay_tab[gap_idx % 64];
				gap_idx <= gap_idx + 1;
			end else if (gap > 0)
				gap <= gap - 1;
		end
	end

	// ##########################################################
	task automatic check_val(input string name, input logic [63:0] got,
	                         input logic [63:0] exp);
		assert (got == exp) else begin
			$display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	// Host byte with wr raised only while dl_wait is low
	task automatic send_byte(input dl_index_t idx, input dl_addr_t a, input byte_t d);
		@(negedge clk_sys);
		while (dl_wait) begin
			saw_wait = 1'b1;
			@(negedge clk_sys);
		end
		@(posedge clk_sys);
		dl <= '{wr: 1'b1, index: idx, addr: a, data: d};
		@(posedge clk_sys);
		dl.wr <= 1'b0;  // Taken on this edge
	endtask

	task automatic read_word(input prog_addr_t a, input prog_word_t exp);
		@(posedge clk_sys);
		prog_addr <= a;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_val("prog_data", 64'(prog_data), 64'(exp));
	endtask

	task automatic key_event(input byte_t code, input logic ext, input logic down);
		@(posedge clk_sys);
		kbd <= '{toggle: ~kbd.toggle, pressed: down, extended: ext, code: code};
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic set_joys(input joy_t j0, input joy_t j1);
		@(posedge clk_sys);
		joy0 <= j0;
		joy1 <= j1;
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	// ##########################################################
	initial begin
		byte_t hi;
		byte_t lo;
		seed     = 31;
		errors   = 0;
		cycles   = 0;
		saw_wait = 1'b0;
		dip_exp  = '0;
		for (int i = 0; i < 64; i++)
			delay_tab[i] = {$random(seed)} % 6;
		rst_n      = 1'b0;
		dl         = '0;
		gfx_credit = 1'b0;
		prog_addr  = '0;
		kbd        = '0;
		joy0       = '0;
		joy1       = '0;
		repeat (3) @(posedge clk_sys);
		rst_n <= 1'b1;
		@(negedge clk_sys);
		check_val("dl_wait", 64'(dl_wait), 64'h0);
		check_val("gfx_wr.valid", 64'(gfx_wr.valid), 64'h0);
		check_val("p1", 64'(p1), 64'hFF);
		check_val("p2", 64'(p2), 64'hFF);
		check_val("p3", 64'(p3), 64'hFF);
		check_val("p4", 64'(p4), 64'hFF);
		check_val("sys_in", 64'(sys_in), 64'h1F);

		// Switches and a plain variant
		for (int n = 0; n < 8; n++) begin
			hi = byte_t'($random(seed));
			dip_exp[n*8 +: 8] = hi;
			send_byte(`IDX_DIP, dl_addr_t'(n), hi);
		end
		send_byte(`IDX_GAME, '0, 8'd5);
		@(negedge clk_sys);
		check_val("dip_sw", dip_sw, dip_exp);
		check_val("game_type", 64'(game_type), 64'h5);

		// Graphics bytes while memory stalls the first credits
		for (int i = 0; i < N_GFX; i++)
			send_byte(`IDX_ROM, dl_addr_t'('h400 + i), byte_t'($random(seed)));
		while (words_seen < N_GFX / 4 || owed != 0)
			@(negedge clk_sys);
		check_val("gfx words", 64'(words_seen), 64'(N_GFX / 4));
		assert (saw_wait) else begin
			$display("Credit stall never raised dl_wait");
			errors++;
		end

		// Two words into every program bank
		for (int k = 0; k < 6; k++) begin
			for (int w = 0; w < 2; w++) begin
				hi = byte_t'($random(seed));
				lo = byte_t'($random(seed));
				prog_exp[k][w] = {hi, lo};
				send_byte(`IDX_ROM, dl_addr_t'(DL_BASE[k] + 2 * (WORD_OFS + w)), hi);
				send_byte(`IDX_ROM, dl_addr_t'(DL_BASE[k] + 2 * (WORD_OFS + w) + 1), lo);
			end
		end
		for (int k = 0; k < 6; k++)
			for (int w = 0; w < 2; w++)
				read_word(prog_addr_t'(RD_BASE[k] + WORD_OFS + w), prog_exp[k][w]);
		read_word(19'h08000, '0);  // Holes in the map
		read_word(19'h1C000, '0);

		// ##########################################################
		// Normal layout
		key_event(`KEY_UP, 1'b1, 1'b1);
		check_val("p1", 64'(p1), 64'h7F);
		key_event(`KEY_UP, 1'b1, 1'b0);
		check_val("p1", 64'(p1), 64'hFF);
		key_event(`KEY_CTRL, 1'b0, 1'b1);
		check_val("p1", 64'(p1), 64'hFD);
		key_event(`KEY_CTRL, 1'b0, 1'b0);
		key_event(`KEY_R, 1'b0, 1'b1);
		check_val("p2", 64'(p2), 64'h7F);
		key_event(`KEY_R, 1'b0, 1'b0);
		key_event(`KEY_5, 1'b0, 1'b1);
		check_val("sys_in", 64'(sys_in), 64'h17);
		key_event(`KEY_5, 1'b0, 1'b0);
		key_event(`KEY_8, 1'b0, 1'b1);
		check_val("sys_in", 64'(sys_in), 64'h1E);
		key_event(`KEY_8, 1'b0, 1'b0);
		set_joys(16'h0008, 16'h0001);  // P1 up, P2 right
		check_val("p1", 64'(p1), 64'h7F);
		check_val("p2", 64'(p2), 64'hEF);
		set_joys(16'h0010, 16'h0100);  // Fire and coin 2
		check_val("p1", 64'(p1), 64'hFE);
		check_val("sys_in", 64'(sys_in), 64'h1B);
		set_joys('0, '0);

		// Tank layout
		send_byte(`IDX_GAME, '0, `GAME_TANK);
		@(negedge clk_sys);
		check_val("game_type", 64'(game_type), 64'(`GAME_TANK));
		for (int d = 0; d < 8; d++) begin
			set_joys(joy_t'(DIRS[d]), joy_t'(DIRS[d]));
			check_val("p1", 64'(p1), 64'(TANK_P[d]));
			check_val("p2", 64'(p2), 64'(TANK_P[d]));
		end
		set_joys(16'h0200, '0);  // Stick start
		check_val("p3", 64'(p3), 64'hFE);
		set_joys('0, '0);
		key_event(`KEY_W, 1'b0, 1'b1);
		check_val("p1", 64'(p1), 64'hEF);
		key_event(`KEY_W, 1'b0, 1'b0);
		key_event(`KEY_K, 1'b0, 1'b1);
		check_val("p2", 64'(p2), 64'h7F);
		key_event(`KEY_K, 1'b0, 1'b0);
		key_event(`KEY_1, 1'b0, 1'b1);
		check_val("p3", 64'(p3), 64'hFE);
		key_event(`KEY_1, 1'b0, 1'b0);
		key_event(`KEY_6, 1'b0, 1'b1);
		check_val("sys_in", 64'(sys_in), 64'h1B);
		key_event(`KEY_6, 1'b0, 1'b0);
		key_event(`KEY_UP, 1'b1, 1'b1);  // Arrows unused here
		check_val("p1", 64'(p1), 64'hFF);
		key_event(`KEY_UP, 1'b1, 1'b0);

		repeat (5) @(posedge clk_sys);
		prop_errors = dut.u_props.cred_fails + dut.u_props.out_fails +
		              dut.u_props.gfx_fails + dut.u_props.cfg_fails;
		$display("Errors: %0d value checks, %0d assertion failures", errors, prop_errors);
		if (errors == 0 && prop_errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

//--- bench/arcade_io_properties.sv
/*
 * Arcade IO properties
 * Credit flow, graphics words, switches and variant, bound to the top
 */
`timescale 1ns/1ps
`include "arcade_consts.svh"

module arcade_io_properties (
	input logic                   clk_sys,
	input logic                   rst_n,
	input arcade_pkg::dl_byte_t   dl,
	input logic                   dl_wait,
	input arcade_pkg::gfx_wr_t    gfx_wr,
	input logic                   gfx_credit,
	input logic [63:0]            dip_sw,
	input arcade_pkg::game_type_t game_type
);
	import arcade_pkg::*;

	int unsigned cred_fails = 0;  // Failures per rule
	int unsigned out_fails  = 0;
	int unsigned gfx_fails  = 0;
	int unsigned cfg_fails  = 0;

	int          cred;            // Credits the router should hold
	int          outstanding;     // Words not yet returned
	logic        take;
	logic        issue;
	byte_t [2:0] hist;            // [2] oldest ROM byte
	logic        exp_valid;
	gfx_addr_t   exp_addr;
	gfx_word_t   exp_data;
	logic [63:0] exp_dip;
	game_type_t  exp_game;

	assign take  = dl.wr && !dl_wait;
	// Graphics region ends at 3 x 256 KB
	assign issue = take && dl.index == `IDX_ROM && dl.addr < 25'h0C0000 &&
	               dl.addr[1:0] == 2'b11;

	// ##########################################################
	// Expected values from the stream
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			cred        <= `GFX_CREDITS;
			outstanding <= 0;
			exp_valid   <= 1'b0;
			exp_dip     <= '0;
			exp_game    <= '0;
		end else begin
			cred        <= cred - int'(issue) + int'(gfx_credit);
			outstanding <= outstanding + int'(gfx_wr.valid) - int'(gfx_credit);
			exp_valid   <= issue;
			if (issue) begin
				exp_addr <= gfx_addr_t'(dl.addr >> 2);  // Dword address
				exp_data <= {hist, dl.data};
			end
			if (take && dl.index == `IDX_ROM)
				hist <= {hist[1:0], dl.data};
			if (take && dl.index == `IDX_DIP && dl.addr < 25'd8)
				exp_dip[{dl.addr[2:0], 3'b000} +: 8] <= dl.data;
			if (take && dl.index == `IDX_GAME)
				exp_game <= dl.data;
		end
	end

	// ##########################################################
	a_wait: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dl_wait == (cred == 0))
		else begin
			cred_fails++;
			$error("dl_wait does not follow the credit count");
		end

	a_outstanding: assert property (@(posedge clk_sys) disable iff (!rst_n)
		outstanding >= 0 && outstanding <= `GFX_CREDITS)
		else begin
			out_fails++;
			$error("Graphics words in flight exceed the credits");
		end

	a_gfx: assert property (@(posedge clk_sys) disable iff (!rst_n)
		gfx_wr.valid == exp_valid &&
		(!exp_valid || (gfx_wr.addr == exp_addr && gfx_wr.data == exp_data)))
		else begin
			gfx_fails++;
			$error("Graphics write differs from the byte stream");
		end

	a_cfg: assert property (@(posedge clk_sys) disable iff (!rst_n)
		dip_sw == exp_dip && game_type == exp_game)
		else begin
			cfg_fails++;
			$error("Switches or variant differ from the download");
		end

endmodule

bind arcade_io_top arcade_io_properties u_props (
	.clk_sys    (clk_sys),
	.rst_n      (rst_n),
	.dl         (dl),
	.dl_wait    (dl_wait),
	.gfx_wr     (gfx_wr),
	.gfx_credit (gfx_credit),
	.dip_sw     (dip_sw),
	.game_type  (game_type)
);

//--- src/arcade_io_top.sv
/*
 * Arcade IO top
 * Download router, program ROM and input mapper
 */
`timescale 1ns/1ps

module arcade_io_top (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  arcade_pkg::dl_byte_t     dl,
	output logic                     dl_wait,
	output arcade_pkg::gfx_wr_t      gfx_wr,
	input  logic                     gfx_credit,
	input  arcade_pkg::prog_addr_t   prog_addr,
	output arcade_pkg::prog_word_t   prog_data,
	input  arcade_pkg::kbd_event_t   kbd,
	input  arcade_pkg::joy_t         joy0,
	input  arcade_pkg::joy_t         joy1,
	output arcade_pkg::player_port_t p1,
	output arcade_pkg::player_port_t p2,
	output arcade_pkg::player_port_t p3,
	output arcade_pkg::player_port_t p4,
	output logic [4:0]               sys_in,
	output logic [63:0]              dip_sw,
	output arcade_pkg::game_type_t   game_type
);
	import arcade_pkg::*;

	prog_wr_t   prog_wr;    // Router to ROM banks
	game_type_t game_sel;   // Variant, also picks key layout

	download_router u_router (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.dl         (dl),
		.dl_wait    (dl_wait),
		.gfx_wr     (gfx_wr),
		.gfx_credit (gfx_credit),
		.prog_wr    (prog_wr),
		.dip_sw     (dip_sw),
		.game_type  (game_sel)
	);

	program_rom u_prog_rom (
		.clk_sys   (clk_sys),
		.prog_wr   (prog_wr),
		.prog_addr (prog_addr),
		.prog_data (prog_data)
	);

	input_mapper u_inputs (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.kbd       (kbd),
		.joy0      (joy0),
		.joy1      (joy1),
		.game_type (game_sel),
		.p1        (p1),
		.p2        (p2),
		.p3        (p3),
		.p4        (p4),
		.sys_in    (sys_in)
	);

	assign game_type = game_sel;

endmodule

//--- src/input_mapper.sv
/*
 * Input mapper
 * Keyboard and joystick state onto the active-low player and coin ports,
 * with a twin-stick tank layout for the tank variant
 */
`timescale 1ns/1ps
`include "arcade_consts.svh"

module input_mapper (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  arcade_pkg::kbd_event_t   kbd,
	input  arcade_pkg::joy_t         joy0,
	input  arcade_pkg::joy_t         joy1,
	input  arcade_pkg::game_type_t   game_type,
	output arcade_pkg::player_port_t p1,
	output arcade_pkg::player_port_t p2,
	output arcade_pkg::player_port_t p3,
	output arcade_pkg::player_port_t p4,
	output logic [4:0]               sys_in
);
	import arcade_pkg::*;

	logic         is_tank;
	logic         toggle_q;
	logic [6:0]   key_sel;     // {hit, slot}
	logic [35:0]  key_held;    // Ports p1..p4 then coins 1..4
	logic [9:0]   joy0_q;
	logic [9:0]   joy1_q;
	logic [3:0]   tank0_q;     // {x_bk, w_bk, x_fw, w_fw}
	logic [3:0]   tank1_q;
	player_port_t joy_p1;
	player_port_t joy_p2;
	player_port_t joy_p3;

	// Slot = port*8 + bit, coins from 32
	function automatic logic [6:0] key_slot(input logic tank, input logic ext,
	                                        input byte_t code);
		logic [6:0] s;
		s = '0;
		if (tank) begin
			if (!ext) begin
				case (code)
					`KEY_D: s = {1'b1, 6'd7};   // P1 right back
					`KEY_S: s = {1'b1, 6'd6};   // P1 left back
					`KEY_E: s = {1'b1, 6'd5};   // P1 right forward
					`KEY_W: s = {1'b1, 6'd4};   // P1 left forward
					`KEY_R: s = {1'b1, 6'd3};   // P1 thumbs
					`KEY_Q: s = {1'b1, 6'd2};
					`KEY_F: s = {1'b1, 6'd1};   // P1 triggers
					`KEY_A: s = {1'b1, 6'd0};
					`KEY_K: s = {1'b1, 6'd15};  // P2, same order
					`KEY_J: s = {1'b1, 6'd14};
					`KEY_I: s = {1'b1, 6'd13};
					`KEY_U: s = {1'b1, 6'd12};
					`KEY_O: s = {1'b1, 6'd11};
					`KEY_Y: s = {1'b1, 6'd10};
					`KEY_L: s = {1'b1, 6'd9};
					`KEY_H: s = {1'b1, 6'd8};
					`KEY_1: s = {1'b1, 6'd16};  // Starts on P3
					`KEY_2: s = {1'b1, 6'd17};
					`KEY_5: s = {1'b1, 6'd32};  // Coins
					`KEY_6: s = {1'b1, 6'd33};
					default: ;
				endcase
			end
		end else begin
			case (code)
				// Arrows match with or without the extended flag
				`KEY_UP:    s = {1'b1, 6'd7};
				`KEY_DOWN:  s = {1'b1, 6'd6};
				`KEY_LEFT:  s = {1'b1, 6'd5};
				`KEY_RIGHT: s = {1'b1, 6'd4};
				default: begin
					if (!ext) begin
						case (code)
							`KEY_CTRL: s = {1'b1, 6'd1};   // P1 fire
							`KEY_ALT:  s = {1'b1, 6'd0};   // P1 magic
							`KEY_R:    s = {1'b1, 6'd15};  // P2 up
							`KEY_F:    s = {1'b1, 6'd14};
							`KEY_D:    s = {1'b1, 6'd13};
							`KEY_G:    s = {1'b1, 6'd12};
							`KEY_A:    s = {1'b1, 6'd9};   // P2 fire
							`KEY_S:    s = {1'b1, 6'd8};
							`KEY_5:    s = {1'b1, 6'd32};
							`KEY_6:    s = {1'b1, 6'd33};
							`KEY_7:    s = {1'b1, 6'd34};
							`KEY_8:    s = {1'b1, 6'd35};
							default: ;
						endcase
					end
				end
			endcase
		end
		return s;
	endfunction

	// Up,down,left,right onto left/right tread forward/back
	function automatic logic [3:0] tank_dirs(input logic [3:0] dir);
		logic [3:0] t;
		case (dir)
			4'b1010: t = 4'b0010;  // Up left
			4'b1000: t = 4'b0011;  // Up
			4'b1001: t = 4'b0001;  // Up right
			4'b0001: t = 4'b1001;  // Right, spin
			4'b0101: t = 4'b0100;  // Down right
			4'b0100: t = 4'b1100;  // Down
			4'b0110: t = 4'b1000;  // Down left
			4'b0010: t = 4'b0110;  // Left, spin
			default: t = 4'b0000;
		endcase
		return t;
	endfunction

	assign is_tank = (game_type == `GAME_TANK);
	assign key_sel = key_slot(is_tank, kbd.extended, kbd.code);

	// ##########################################################
	// Held keys and registered sticks

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			toggle_q <= kbd.toggle;  // No event out of reset
			key_held <= '0;
		end else begin
			toggle_q <= kbd.toggle;
			if (toggle_q != kbd.toggle && key_sel[6])
				key_held[key_sel[5:0]] <= kbd.pressed;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			joy0_q  <= '0;
			joy1_q  <= '0;
			tank0_q <= '0;
			tank1_q <= '0;
		end else begin
			joy0_q  <= joy0[9:0];
			joy1_q  <= joy1[9:0];
			tank0_q <= tank_dirs(joy0[3:0]);
			tank1_q <= tank_dirs(joy1[3:0]);
		end
	end

	// ##########################################################
	// Ports, low when pressed

	assign joy_p1 = is_tank ? {tank0_q, joy0_q[7:4]} : {joy0_q[3:0], joy0_q[7:4]};
	assign joy_p2 = is_tank ? {tank1_q, joy1_q[7:4]} : {joy1_q[3:0], joy1_q[7:4]};
	assign joy_p3 = is_tank ? {6'b0, joy1_q[9], joy0_q[9]} : '0;  // Stick starts

	assign p1 = ~(key_held[7:0]   | joy_p1);
	assign p2 = ~(key_held[15:8]  | joy_p2);
	assign p3 = ~(key_held[23:16] | joy_p3);
	assign p4 = ~key_held[31:24];  // Keyboard only

	assign sys_in = {1'b1,                          // Service off
	                 ~(key_held[32] | joy0_q[8]),
	                 ~(key_held[33] | joy1_q[8]),
	                 ~key_held[34],
	                 ~key_held[35]};

endmodule

//--- src/program_rom.sv
/*
 * Program ROM
 * Six 16-bit banks loaded by the router, one registered read port
 */
`timescale 1ns/1ps
`include "arcade_consts.svh"

module program_rom (
	input  logic                    clk_sys,
	input  arcade_pkg::prog_wr_t    prog_wr,
	input  arcade_pkg::prog_addr_t  prog_addr,
	output arcade_pkg::prog_word_t  prog_data
);
	import arcade_pkg::*;

	prog_word_t bank_q [6];  // Per bank read data
	prog_bank_t rd_bank;
	logic       rd_hit;
	prog_bank_t rd_bank_q;
	logic       rd_hit_q;

	// ##########################################################
	// Deep banks 0, 2, 3, 4, 5

	for (genvar g = 0; g < 5; g++) begin : g_deep
		localparam prog_bank_t BANK = (g == 0) ? 3'd0 : 3'(g + 1);

		prog_word_t mem [2**`PROG_BANK_AW];

		always_ff @(posedge clk_sys) begin
			if (prog_wr.valid && prog_wr.bank == BANK)
				mem[prog_wr.addr] <= prog_wr.data;
			bank_q[BANK] <= mem[prog_addr[`PROG_BANK_AW-1:0]];
		end
	end

	// Short bank 1 (10A/10B)
	prog_word_t small_mem [2**`PROG_SMALL_AW];

	always_ff @(posedge clk_sys) begin
		if (prog_wr.valid && prog_wr.bank == 3'd1)
			small_mem[prog_wr.addr[`PROG_SMALL_AW-1:0]] <= prog_wr.data;
		bank_q[1] <= small_mem[prog_addr[`PROG_SMALL_AW-1:0]];
	end

	// ##########################################################
	// Read select

	always_comb begin
		rd_hit  = 1'b1;
		rd_bank = '0;
		if (prog_addr[18:14] == `PA_REG_10AB)
			rd_bank = 3'd1;
		else begin
			case (prog_addr[18:15])
				`PA_REG_9AB: rd_bank = 3'd0;
				`PA_REG_7AB: rd_bank = 3'd2;
				`PA_REG_6AB: rd_bank = 3'd3;
				`PA_REG_5AB: rd_bank = 3'd4;
				`PA_REG_3AB: rd_bank = 3'd5;
				default:     rd_hit  = 1'b0;  // Hole in the map
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		rd_bank_q <= rd_bank;
		rd_hit_q  <= rd_hit;
	end

	assign prog_data = rd_hit_q ? bank_q[rd_bank_q] : '0;

endmodule

//--- src/download_router.sv
/*
 * Download router
 * Splits the host byte stream into switches, variant, graphics dwords
 * and program words, with credit flow control on the graphics side
 */
`timescale 1ns/1ps
`include "arcade_consts.svh"

module download_router (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  arcade_pkg::dl_byte_t  dl,
	output logic                  dl_wait,
	output arcade_pkg::gfx_wr_t   gfx_wr,
	input  logic                  gfx_credit,
	output arcade_pkg::prog_wr_t  prog_wr,
	output logic [63:0]           dip_sw,
	output arcade_pkg::game_type_t game_type
);
	import arcade_pkg::*;

	localparam int CRED_W = $clog2(`GFX_CREDITS + 1);

	logic              accept;     // Byte taken this cycle
	logic              rom_byte;
	logic              gfx_region;
	logic              gfx_issue;
	logic              prog_hit;
	prog_bank_t        prog_bank;
	logic [CRED_W-1:0] credits;
	byte_t [2:0]       acc_bytes;  // [2] oldest
	byte_t [7:0]       dip_q;
	game_type_t        game_q;

	logic       gfx_valid_q;
	gfx_addr_t  gfx_addr_q;
	gfx_word_t  gfx_data_q;
	logic       prog_valid_q;
	prog_bank_t prog_bank_q;
	logic [`PROG_BANK_AW-1:0] prog_addr_q;
	prog_word_t prog_data_q;

	// ##########################################################
	// Byte decode

	assign dl_wait    = (credits == '0);  // Stall while no credit left
	assign accept     = dl.wr && !dl_wait;
	assign rom_byte   = accept && (dl.index == `IDX_ROM);
	assign gfx_region = (dl.addr[24:18] < `GFX_LIMIT);
	assign gfx_issue  = rom_byte && gfx_region && (dl.addr[1:0] == 2'b11);

	// Program bank from the download map
	always_comb begin
		prog_hit  = 1'b1;
		prog_bank = '0;
		if (dl.addr[24:15] == `DL_REG_10AB)
			prog_bank = 3'd1;  // Short bank
		else begin
			case (dl.addr[24:16])
				`DL_REG_9AB: prog_bank = 3'd0;
				`DL_REG_7AB: prog_bank = 3'd2;
				`DL_REG_6AB: prog_bank = 3'd3;
				`DL_REG_5AB: prog_bank = 3'd4;
				`DL_REG_3AB: prog_bank = 3'd5;
				default:     prog_hit  = 1'b0;  // Not program ROM
			endcase
		end
	end

	// Last three ROM bytes
	always_ff @(posedge clk_sys) begin
		if (rom_byte)
			acc_bytes <= {acc_bytes[1:0], dl.data};
	end

	// ##########################################################
	// Graphics channel

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			gfx_valid_q <= 1'b0;
			credits     <= CRED_W'(`GFX_CREDITS);
		end else begin
			gfx_valid_q <= gfx_issue;
			case ({gfx_issue, gfx_credit})
				2'b10:   credits <= credits - 1'b1;  // Word sent
				2'b01:   credits <= credits + 1'b1;  // Word done
				default: ;                           // Both or neither
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (gfx_issue) begin
			gfx_addr_q <= dl.addr[24:2];             // Dword address
			gfx_data_q <= {acc_bytes, dl.data};      // Oldest byte on top
		end
	end

	assign gfx_wr = '{valid: gfx_valid_q, addr: gfx_addr_q, data: gfx_data_q};

	// ##########################################################
	// One program word per odd byte

	always_ff @(posedge clk_sys) begin
		if (!rst_n)
			prog_valid_q <= 1'b0;
		else
			prog_valid_q <= rom_byte && prog_hit && dl.addr[0];
	end

	always_ff @(posedge clk_sys) begin
		if (rom_byte && prog_hit && dl.addr[0]) begin
			prog_bank_q <= prog_bank;
			prog_addr_q <= dl.addr[`PROG_BANK_AW:1];
			prog_data_q <= {acc_bytes[0], dl.data};  // Even byte high
		end
	end

	assign prog_wr = '{bank: prog_bank_q, addr: prog_addr_q,
	                   data: prog_data_q, valid: prog_valid_q};

	// ##########################################################
	// Switches and variant

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			dip_q  <= '0;
			game_q <= '0;
		end else if (accept) begin
			if (dl.index == `IDX_DIP && dl.addr[24:3] == '0)
				dip_q[dl.addr[2:0]] <= dl.data;  // Eight bytes only
			if (dl.index == `IDX_GAME)
				game_q <= dl.data;
		end
	end

	assign dip_sw    = dip_q;
	assign game_type = game_q;

endmodule

//--- src/arcade_pkg.sv
/*
 * Arcade IO types
 * Vector typedefs and the packed structs moved between blocks
 */
`include "arcade_consts.svh"

package arcade_pkg;

	typedef logic [`DL_ADDR_W-1:0]   dl_addr_t;
	typedef logic [`DL_INDEX_W-1:0]  dl_index_t;
	typedef logic [`DL_DATA_W-1:0]   byte_t;
	typedef logic [`GFX_ADDR_W-1:0]  gfx_addr_t;
	typedef logic [31:0]             gfx_word_t;
	typedef logic [`PROG_ADDR_W-1:0] prog_addr_t;
	typedef logic [15:0]             prog_word_t;
	typedef logic [2:0]              prog_bank_t;  // Six banks, 0..5
	typedef logic [7:0]              player_port_t;
	typedef logic [7:0]              game_type_t;
	typedef logic [15:0]             joy_t;        // [3:0] up,down,left,right

	// Host download byte
	typedef struct packed {
		logic      wr;
		dl_index_t index;
		dl_addr_t  addr;
		byte_t     data;
	} dl_byte_t;

	// Graphics memory write
	typedef struct packed {
		logic      valid;
		gfx_addr_t addr;
		gfx_word_t data;
	} gfx_wr_t;

	// Program ROM write
	typedef struct packed {
		prog_bank_t                bank;
		logic [`PROG_BANK_AW-1:0]  addr;
		prog_word_t                data;
		logic                      valid;
	} prog_wr_t;

	// Keyboard event, new event on toggle change
	typedef struct packed {
		logic  toggle;
		logic  pressed;
		logic  extended;
		byte_t code;
	} kbd_event_t;

endpackage

//--- src/arcade_consts.svh
/*
 * Arcade IO constants
 * Bus widths, download and program memory maps, keyboard scan codes
 */
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// ##########################################################
// Widths
`define DL_ADDR_W      25
`define DL_DATA_W      8
`define DL_INDEX_W     8
`define GFX_ADDR_W     23
`define GFX_CREDITS    4     // Words in flight toward graphics memory
`define PROG_ADDR_W    19
`define PROG_BANK_AW   15    // 32K word banks
`define PROG_SMALL_AW  14    // 16K word bank (10A/10B)

// Download index values
`define IDX_ROM        8'd0
`define IDX_GAME       8'd1
`define IDX_DIP        8'd254

`define GAME_TANK      8'd118  // Twin stick variant

// ##########################################################
// Download map regions
`define GFX_LIMIT      7'd3    // addr[24:18] below this is graphics
`define DL_REG_9AB     9'h0C   // addr[24:16]
`define DL_REG_10AB    10'h1E  // addr[24:15], half size
`define DL_REG_7AB     9'h10
`define DL_REG_6AB     9'h11
`define DL_REG_5AB     9'h12
`define DL_REG_3AB     9'h13

// Program address map, prog_addr[18:15] unless noted
`define PA_REG_9AB     4'h0
`define PA_REG_10AB    5'h06   // prog_addr[18:14]
`define PA_REG_7AB     4'h4
`define PA_REG_6AB     4'h5
`define PA_REG_5AB     4'h6
`define PA_REG_3AB     4'h7

// ##########################################################
// Keyboard scan codes, low byte
`define KEY_UP     8'h75
`define KEY_DOWN   8'h72
`define KEY_LEFT   8'h6B
`define KEY_RIGHT  8'h74
`define KEY_CTRL   8'h14
`define KEY_ALT    8'h11
`define KEY_A      8'h1C
`define KEY_D      8'h23
`define KEY_E      8'h24
`define KEY_F      8'h2B
`define KEY_G      8'h34
`define KEY_H      8'h33
`define KEY_I      8'h43
`define KEY_J      8'h3B
`define KEY_K      8'h42
`define KEY_L      8'h4B
`define KEY_O      8'h44
`define KEY_Q      8'h15
`define KEY_R      8'h2D
`define KEY_S      8'h1B
`define KEY_U      8'h3C
`define KEY_W      8'h1D
`define KEY_Y      8'h35
`define KEY_1      8'h16
`define KEY_2      8'h1E
`define KEY_5      8'h2E
`define KEY_6      8'h36
`define KEY_7      8'h3D
`define KEY_8      8'h3E

`endif
